//--- Makefile
# Verilator build and run for the decryption front end

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := decryptTb
FILELIST  := sources.f
OBJDIR    := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- source/busPkg.sv
// ROM bus definitions
`default_nettype none

package busPkg;

    localparam int BYTE_W = 8;
    localparam int ADDR_W = 23;                   // Word address, 16 MB of ROM
    localparam int DATA_W = 16;

    // Range compare uses address bits 22 down to 7
    localparam int RANGE_LSB = 7;

    typedef logic [BYTE_W-1:0] byteT;             // Host byte and Feistel half
    typedef logic [ADDR_W-1:0] wordAddrT;
    typedef logic [DATA_W-1:0] dataT;             // Opcode word

endpackage

`default_nettype wire

//--- source/cipherPkg.sv
// Key configuration definitions
`default_nettype none

package cipherPkg;

    // Raw blob as loaded by the host, one byte per strobe edge
    localparam int BLOB_BYTES = 20;
    localparam int CFG_WORD_W = 16;                           // Raw and scrambled word width
    localparam int BLOB_WORDS = (BLOB_BYTES * 8) / CFG_WORD_W; // Ten words r0 to r9

    // Feistel network shape
    localparam int ROUNDS     = 4;                            // Two per pipeline stage
    localparam int ROT_AMOUNT = 3;                            // Left rotate in round function

    typedef logic [BLOB_BYTES*8-1:0]   blobT;                 // Full shift register
    typedef logic [CFG_WORD_W-1:0]     cfgWordT;              // One 16-bit config word
    typedef logic [4*CFG_WORD_W-1:0]   keyT;                  // k3 k2 k1 k0, k0 lowest
    typedef logic [CFG_WORD_W-1:0]     rangeT;                // Upper limit of ciphered block

endpackage

`default_nettype wire

//--- source/decryptTop.sv
// Decryption front end top
`timescale 1ns/1ps
`default_nettype none

module decryptTop (
    input  logic             clk,
    input  logic             rst,
    input  busPkg::byteT     din,
    input  logic             dinWe,
    input  busPkg::wordAddrT romAddr,
    input  busPkg::dataT     romData,
    input  logic             romStrobe,
    output busPkg::dataT     plainData,
    output logic             plainStrobe
);
    import cipherPkg::*;

    rangeT addrRange;          // Limit of the ciphered region
    keyT   key;

    // Host config side
    keyLoader u_keyLoader (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .dinWe     (dinWe),
        .addrRange (addrRange),
        .key       (key)
    );

    // ROM fetch side, two cycle latency
    opcodeDecrypter u_decrypter (
        .clk         (clk),
        .rst         (rst),
        .romAddr     (romAddr),
        .romData     (romData),
        .romStrobe   (romStrobe),
        .addrRange   (addrRange),
        .key         (key),
        .plainData   (plainData),
        .plainStrobe (plainStrobe)
    );

endmodule

`default_nettype wire

//--- source/keyLoader.sv
// Configuration key loader
`timescale 1ns/1ps
`default_nettype none

module keyLoader (
    input  logic             clk,
    input  logic             rst,
    input  busPkg::byteT     din,
    input  logic             dinWe,
    output cipherPkg::rangeT addrRange,
    output cipherPkg::keyT   key
);
    import cipherPkg::*;
    import busPkg::*;

    logic    dinWeLast;                 // Strobe level one cycle back
    logic    loadByte;                  // Rising edge of dinWe
    blobT    blob;                      // Raw config, newest byte on top
    cfgWordT rawWord [BLOB_WORDS];      // Blob viewed as r0..r9

    // Bit shuffle of one config word
    // MSB first: raw bits 10..15, raw bits 0..7, then prev bits 8 and 9
    function automatic cfgWordT scrambleWord(
        input cfgWordT rawW,
        input cfgWordT prevW
    );
        cfgWordT w;
        for (int i = 0; i < 6; i++) begin
            w[15 - i] = rawW[10 + i];   // Upper six raw bits, reversed order
        end
        for (int i = 0; i < 8; i++) begin
            w[9 - i] = rawW[i];         // Low raw byte, reversed order
        end
        w[1] = prevW[8];                // Borrowed from the word below
        w[0] = prevW[9];
        return w;
    endfunction

    assign loadByte = dinWe & ~dinWeLast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dinWeLast <= 1'b0;
            blob      <= '0;            // Zero range, all words pass through
        end else begin
            dinWeLast <= dinWe;
            if (loadByte) begin
                // New byte on top, older bytes move down
                blob <= {din, blob[$bits(blobT)-1:$bits(byteT)]};
            end
        end
    end

    // Split into raw words
    always_comb begin
        for (int n = 0; n < BLOB_WORDS; n++) begin
            rawWord[n] = blob[n*CFG_WORD_W +: CFG_WORD_W];
        end
    end

    // c9 comes from r0, wrapping back to r9 for its low bits
    assign addrRange = scrambleWord(rawWord[0], rawWord[BLOB_WORDS-1]);

    // c3 from r7, c2 from r6, c1 from r9, c0 from r8
    assign key = {
        scrambleWord(rawWord[7], rawWord[6]),     // k3
        scrambleWord(rawWord[6], rawWord[5]),     // k2
        scrambleWord(rawWord[9], rawWord[8]),     // k1
        scrambleWord(rawWord[8], rawWord[7])      // k0
    };

endmodule

`default_nettype wire

//--- source/opcodeDecrypter.sv
// Pipelined opcode decrypter
`timescale 1ns/1ps
`default_nettype none

module opcodeDecrypter (
    input  logic               clk,
    input  logic               rst,
    input  busPkg::wordAddrT   romAddr,
    input  busPkg::dataT       romData,
    input  logic               romStrobe,
    input  cipherPkg::rangeT   addrRange,
    input  cipherPkg::keyT     key,
    output busPkg::dataT       plainData,
    output logic               plainStrobe
);
    import cipherPkg::*;
    import busPkg::*;

    localparam int STAGE_ROUNDS = ROUNDS / 2;     // Rounds done per pipe stage

    logic  inRange;            // Address below the limit
    dataT  cipher1Next;        // After rounds 0 and 1
    dataT  cipher2;            // After rounds 2 and 3
    dataT  cipherOut;          // Halves swapped for output

    // Stage one registers
    logic  s1Strobe;
    logic  s1InRange;
    byteT  s1AddrByte;         // Address part that feeds the subkeys
    keyT   s1Key;              // Key travels with the word
    dataT  s1Data;             // Original word for bypass
    dataT  s1Cipher;

    // Round function F(R) for round key ki
    function automatic byteT roundFunc(
        input byteT    r,
        input cfgWordT ki,
        input byteT    addrByte
    );
        byteT subkey;
        byteT sum;
        byteT rot;
        subkey = ki[7:0] ^ addrByte;               // Address tweaks the subkey
        sum    = r + subkey;                       // Mod 256
        rot    = (sum << ROT_AMOUNT) | (sum >> ($bits(byteT) - ROT_AMOUNT));
        return rot ^ ki[15:8];
    endfunction

    // One Feistel round on {L, R}
    function automatic dataT feistelRound(
        input dataT    lr,
        input cfgWordT ki,
        input byteT    addrByte
    );
        byteT l;
        byteT r;
        l = lr[15:8];
        r = lr[7:0];
        return {r, l ^ roundFunc(r, ki, addrByte)};   // New L is old R
    endfunction

    // Rounds first .. first+STAGE_ROUNDS-1
    function automatic dataT runRounds(
        input dataT lr,
        input keyT  k,
        input byteT addrByte,
        input int   first
    );
        dataT st;
        int   idx;
        st = lr;
        for (int i = 0; i < STAGE_ROUNDS; i++) begin
            idx = first + i;
            st  = feistelRound(st, k[idx*$bits(cfgWordT) +: $bits(cfgWordT)], addrByte);
        end
        return st;
    endfunction

    // Stage one combinational part
    assign inRange     = romAddr[$bits(wordAddrT)-1:RANGE_LSB] < addrRange;
    assign cipher1Next = runRounds(romData, key, romAddr[7:0], 0);

    // Stage two combinational part
    assign cipher2   = runRounds(s1Cipher, s1Key, s1AddrByte, STAGE_ROUNDS);
    assign cipherOut = {cipher2[7:0], cipher2[15:8]};     // Final R high, final L low

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1Strobe    <= 1'b0;
            plainStrobe <= 1'b0;
        end else begin
            s1Strobe    <= romStrobe;
            plainStrobe <= s1Strobe;
        end
    end

    // Stage one payload, captured on a fetch
    always_ff @(posedge clk) begin
        if (romStrobe) begin
            s1InRange  <= inRange;
            s1AddrByte <= romAddr[7:0];
            s1Key      <= key;
            s1Data     <= romData;
            s1Cipher   <= cipher1Next;
        end
    end

    // Stage two payload
    always_ff @(posedge clk) begin
        if (s1Strobe) begin
            plainData <= s1InRange ? cipherOut : s1Data;  // Above limit passes as is
        end
    end

endmodule

`default_nettype wire

//--- sources.f
source/cipherPkg.sv
source/busPkg.sv
source/keyLoader.sv
source/opcodeDecrypter.sv
source/decryptTop.sv
tb/decryptTb.sv

//--- tb/decryptTb.sv
// Decryption front end testbench
`timescale 1ns/1ps
`default_nettype none

module decryptTb;
    import cipherPkg::*;
    import busPkg::*;

    localparam int NUM_TESTS  = 10;
    localparam int WAIT_LIMIT = 40;            // Cycles allowed for all pulses
    localparam int SETTLE     = 4;             // Extra cycles to catch stray pulses
    localparam int LATENCY    = 2;             // romStrobe to plainStrobe

    typedef enum {K_FETCH, K_LOAD, K_LOAD_TOP, K_RANGE, K_BURST, K_HELD, K_SAMEDATA} kindT;

    typedef struct {
        kindT     kind;
        int       count;                       // Burst length or held cycles
        wordAddrT addr;
        dataT     data;
    } stimT;

    logic     clk;
    logic     rst;
    byteT     din;
    logic     dinWe;
    wordAddrT romAddr;
    dataT     romData;
    logic     romStrobe;
    dataT     plainData;
    logic     plainStrobe;

    stimT     stimTable [NUM_TESTS];
    blobT     modelBlob;                       // Reference copy of the loader state
    int       srcRaw [BLOB_WORDS] = '{8, 9, 6, 7, 5, 4, 3, 2, 1, 0};  // c0..c9 source
    integer   seed = 9187;
    int       cycleCount = 0;
    int       errCount = 0;
    int       passCount = 0;
    int       failCount = 0;
    int       errBefore;

    wordAddrT reqAddr [$];                     // Fetches waiting to be driven
    dataT     reqData [$];
    dataT     expData [$];
    int       sentCycle [$];
    dataT     gotData [$];
    int       gotCycle [$];

    decryptTop i_dut (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .dinWe       (dinWe),
        .romAddr     (romAddr),
        .romData     (romData),
        .romStrobe   (romStrobe),
        .plainData   (plainData),
        .plainStrobe (plainStrobe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                 // 4 ns period
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Output monitor, sampled mid cycle where outputs are stable
    always @(negedge clk) begin
        if (plainStrobe === 1'b1) begin
            gotData.push_back(plainData);
            gotCycle.push_back(cycleCount);
        end
    end

    function automatic byteT randomByte();
        logic [31:0] v;
        v = $random(seed);
        return v[7:0];
    endfunction

    function automatic dataT randomWord();
        logic [31:0] v;
        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic void modelShift(input byteT b);
        modelBlob = {b, modelBlob[$bits(blobT)-1:8]};   // Newest byte on top
    endfunction

    // MSB first: raw 10..15, raw 0..7, prev 8 and 9
    function automatic cfgWordT scrambleRaw(input cfgWordT r, input cfgWordT p);
        return {r[10], r[11], r[12], r[13], r[14], r[15],
                r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7], p[8], p[9]};
    endfunction

    function automatic cfgWordT cfgWord(input int c);
        int src;
        int prv;
        src = srcRaw[c];
        prv = (src + BLOB_WORDS - 1) % BLOB_WORDS;       // r0 wraps to r9
        return scrambleRaw(modelBlob[src*16 +: 16], modelBlob[prv*16 +: 16]);
    endfunction

    function automatic dataT modelDecrypt(input wordAddrT a, input dataT d);
        rangeT   lim;
        keyT     k;
        cfgWordT ki;
        byteT    l;
        byteT    r;
        byteT    t;
        byteT    sum;
        byteT    f;
        lim = cfgWord(9);
        k   = {cfgWord(3), cfgWord(2), cfgWord(1), cfgWord(0)};
        if (a[$bits(wordAddrT)-1:RANGE_LSB] >= lim) begin
            return d;                          // Outside the ciphered block
        end
        l = d[15:8];
        r = d[7:0];
        for (int i = 0; i < ROUNDS; i++) begin
            ki  = k[i*16 +: 16];
            sum = r + (ki[7:0] ^ a[7:0]);
            f   = {sum[4:0], sum[7:5]} ^ ki[15:8];   // Rotate left by 3
            t   = r;
            r   = l ^ f;
            l   = t;
        end
        return {r, l};
    endfunction

    task automatic checkData(input string name, input dataT exp, input dataT got);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkStrobeCount(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkLatency(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic sendByte(input byteT b);
        @(posedge clk);
        #1;
        din   = b;
        dinWe = 1'b1;
        @(posedge clk);
        #1;
        dinWe = 1'b0;                          // Low again so the next byte is an edge
        modelShift(b);
    endtask

    task automatic loadBlob(input logic topRange);
        byteT bytes [BLOB_BYTES];
        for (int i = 0; i < BLOB_BYTES; i++) begin
            bytes[i] = randomByte();
        end
        if (topRange) begin
            bytes[0]     = 8'hFF;              // r0 all ones
            bytes[1]     = 8'hFF;
            bytes[19][1:0] = 2'b11;            // r9 bits 8 and 9
        end
        for (int i = 0; i < BLOB_BYTES; i++) begin
            sendByte(bytes[i]);
        end
    endtask

    task automatic holdStrobe(input int cycles);
        byteT b;
        @(posedge clk);
        #1;
        b     = randomByte();
        din   = b;
        dinWe = 1'b1;
        modelShift(b);                         // Only the first byte counts
        for (int k = 1; k < cycles; k++) begin
            @(posedge clk);
            #1;
            din = randomByte();
        end
        @(posedge clk);
        #1;
        dinWe = 1'b0;
    endtask

    task automatic queueFetch(input wordAddrT a, input dataT d);
        reqAddr.push_back(a);
        reqData.push_back(d);
    endtask

    // Drive queued fetches back to back, then collect and compare
    task automatic runFetches();
        int waited;
        int n;
        gotData.delete();
        gotCycle.delete();
        expData.delete();
        sentCycle.delete();
        foreach (reqAddr[i]) begin
            @(posedge clk);
            #1;
            romAddr   = reqAddr[i];
            romData   = reqData[i];
            romStrobe = 1'b1;
            expData.push_back(modelDecrypt(reqAddr[i], reqData[i]));
            sentCycle.push_back(cycleCount);
        end
        @(posedge clk);
        #1;
        romStrobe = 1'b0;
        waited = 0;
        while (gotData.size() < expData.size() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (gotData.size() < expData.size()) begin
            $display("Timed out waiting for plainStrobe, saw %0d of %0d pulses",
                     gotData.size(), expData.size());
            errCount++;
        end
        repeat (SETTLE) @(posedge clk);
        checkStrobeCount("plainStrobe pulses", expData.size(), gotData.size());
        n = (gotData.size() < expData.size()) ? gotData.size() : expData.size();
        for (int i = 0; i < n; i++) begin
            checkData("plainData", expData[i], gotData[i]);
            checkLatency("plainStrobe latency", LATENCY, gotCycle[i] - sentCycle[i]);
        end
        reqAddr.delete();
        reqData.delete();
    endtask

    task automatic runTest(input int t);
        stimT  rec;
        rangeT lim;
        rangeT below;
        rec = stimTable[t];
        case (rec.kind)
            K_FETCH: queueFetch(rec.addr, rec.data);
            K_LOAD, K_LOAD_TOP: begin
                loadBlob(rec.kind == K_LOAD_TOP);
                queueFetch(rec.addr, rec.data);
            end
            K_RANGE: begin
                lim = cfgWord(9);
                if (lim != '0) begin
                    below = lim - 16'd1;       // Last block inside the range
                    queueFetch({below, rec.addr[6:0]}, rec.data);
                end
                queueFetch({lim, rec.addr[6:0]}, rec.data);
            end
            K_BURST: begin
                for (int i = 0; i < rec.count; i++) begin
                    queueFetch(rec.addr + wordAddrT'(i), randomWord());
                end
            end
            K_HELD: begin
                holdStrobe(rec.count);
                queueFetch(rec.addr, rec.data);
            end
            K_SAMEDATA: begin
                queueFetch(rec.addr, rec.data);
                queueFetch(rec.addr ^ 23'h000055, rec.data);  // Other subkey byte
            end
            default: queueFetch(rec.addr, rec.data);
        endcase
        runFetches();
    endtask

    initial begin
        rst       = 1'b1;
        din       = '0;
        dinWe     = 1'b0;
        romAddr   = '0;
        romData   = '0;
        romStrobe = 1'b0;
        modelBlob = '0;                        // Matches the reset blob

        stimTable[0] = '{K_FETCH,    1, 23'h001234, 16'hBEEF};
        stimTable[1] = '{K_LOAD,     0, 23'h000000, 16'h1357};
        stimTable[2] = '{K_RANGE,    0, 23'h00002A, 16'hC0DE};
        stimTable[3] = '{K_BURST,    6, 23'h000040, 16'h0000};
        stimTable[4] = '{K_HELD,     5, 23'h000010, 16'h4E71};
        stimTable[5] = '{K_LOAD_TOP, 0, 23'h3A0000, 16'h600D};
        stimTable[6] = '{K_SAMEDATA, 0, 23'h000100, 16'hA5A5};
        stimTable[7] = '{K_BURST,    4, 23'h7FFF7E, 16'h0000};  // Straddles top block
        stimTable[8] = '{K_LOAD,     0, 23'h000000, 16'h1357};  // Reload, new key
        stimTable[9] = '{K_BURST,    5, 23'h000200, 16'h0000};

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errBefore = errCount;
            runTest(t);
            if (errCount == errBefore) begin
                passCount++;
                $display("Test %0d %s: ok", t, stimTable[t].kind.name());
            end else begin
                failCount++;
                $display("Test %0d %s: FAILED", t, stimTable[t].kind.name());
            end
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
